//--- design/link_test_pkg.sv
package link_test_pkg;

    // ====================
    // Word and LFSR
    // ====================

    // Serializer ratio, also the PRBS word size
    localparam int WORD_WIDTH = 8;

    // LFSR state right after reset
    localparam logic [WORD_WIDTH-1:0] LFSR_SEED = 8'h01;

    // x^8+x^6+x^5+x^4+1, feedback from state bits 7, 5, 4 and 3
    localparam logic [WORD_WIDTH-1:0] LFSR_TAPS = 8'b1011_1000;

    // ====================
    // Serializer and checker
    // ====================

    // Slow-clock cycles the serializer stays in reset
    localparam int SER_RST_CYCLES = 4;

    // Mismatches needed to raise the error flag
    localparam int ERROR_COUNT = 16;
    localparam int ERR_CNT_W   = $clog2(ERROR_COUNT + 1);

    // PRBS word with its one-cycle load strobe
    typedef struct packed {
        logic                  load;
        logic [WORD_WIDTH-1:0] data;
    } prbs_word_t;

    // One bit slot as seen by the comparator
    typedef struct packed {
        logic ref_bit;
        logic iob_bit;
        logic armed;
    } bit_pair_t;

endpackage

//--- design/prbs_gen.sv
`timescale 1ns/1ps

module prbs_gen (
    input  logic                     CLK,
    input  logic                     RST,
    input  logic                     ce,
    output link_test_pkg::prbs_word_t word
);

    import link_test_pkg::*;

    logic [WORD_WIDTH-1:0] state;
    logic                  load_r;
    logic                  feedback;

    // XOR of the tapped bits
    assign feedback = ^(state & LFSR_TAPS);

    // One LFSR step per word strobe
    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            state  <= LFSR_SEED;
            load_r <= 1'b0;
        end else begin
            if (ce) begin
                state <= {state[WORD_WIDTH-2:0], feedback};
            end
            // Strobe trails the state update so consumers see a settled word
            load_r <= ce;
        end
    end

    assign word.load = load_r;
    assign word.data = state;

endmodule

//--- design/word_serializer.sv
`timescale 1ns/1ps

module word_serializer (
    input  logic                     CLK,
    input  logic                     CLKDIV,
    input  logic                     RST,
    input  link_test_pkg::prbs_word_t word,
    output logic                     ser_ready,
    output logic                     dat
);

    import link_test_pkg::*;

    // ====================
    // Slow clock side
    // ====================

    logic [WORD_WIDTH-1:0]     ser_dat;
    logic [SER_RST_CYCLES-1:0] ser_rst_sr;
    logic                      ser_rst;

    // Word capture on the CLKDIV rising edge
    always_ff @(posedge CLKDIV or posedge RST) begin
        if (RST) begin
            ser_dat <= '0;
        end else begin
            ser_dat <= word.data;
        end
    end

    // Reset sequencer
    // Preset by RST, drains one bit per CLKDIV edge
    always_ff @(posedge CLKDIV or posedge RST) begin
        if (RST) begin
            ser_rst_sr <= '1;
        end else begin
            ser_rst_sr <= ser_rst_sr >> 1;
        end
    end

    assign ser_rst   = ser_rst_sr[0];
    assign ser_ready = ~ser_rst;

    // ====================
    // Fast clock side
    // ====================

    logic [WORD_WIDTH-1:0] shift_sr;

    // Parallel load on the strobe, then LSB first
    // Captured word is one CLKDIV period old by the time it loads
    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            shift_sr <= '0;
        end else if (ser_rst) begin
            // Line stays low while the serializer is in reset
            shift_sr <= '0;
        end else if (word.load) begin
            shift_sr <= ser_dat;
        end else begin
            shift_sr <= shift_sr >> 1;
        end
    end

    // Output bit straight from the register
    assign dat = shift_sr[0];

endmodule

//--- design/ref_serializer.sv
`timescale 1ns/1ps

module ref_serializer (
    input  logic                     CLK,
    input  logic                     RST,
    input  link_test_pkg::prbs_word_t word,
    input  logic                     ser_ready,
    output logic                     ref_bit,
    output logic                     armed
);

    import link_test_pkg::*;

    logic [WORD_WIDTH-1:0] prev_word;
    logic [WORD_WIDTH-1:0] ref_sr;
    logic [1:0]            strobe_cnt;

    // ====================
    // Reference stream
    // ====================

    // One-word delay matches the serializer capture latency
    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            prev_word <= '0;
            ref_sr    <= '0;
        end else if (word.load) begin
            prev_word <= word.data;
            ref_sr    <= prev_word;
        end else begin
            ref_sr <= ref_sr >> 1;
        end
    end

    assign ref_bit = ref_sr[0];

    // ====================
    // Compare enable
    // ====================

    // Count strobes once the serializer is out of reset
    // First word after reset is skipped
    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            strobe_cnt <= '0;
            armed      <= 1'b0;
        end else if (ser_ready && word.load && !armed) begin
            strobe_cnt <= strobe_cnt + 2'd1;
            if (strobe_cnt == 2'd1) begin
                armed <= 1'b1;
            end
        end
    end

endmodule

//--- design/bit_error_monitor.sv
`timescale 1ns/1ps

module bit_error_monitor #(
    parameter int ERROR_HOLD = 64
) (
    input  logic                    CLK,
    input  logic                    RST,
    input  link_test_pkg::bit_pair_t bits,
    output logic                    error
);

    import link_test_pkg::*;

    localparam int HOLD_W = (ERROR_HOLD > 1) ? $clog2(ERROR_HOLD) : 1;

    logic                 mismatch;
    logic                 hold_done;
    logic [ERR_CNT_W-1:0] err_cnt;
    logic [HOLD_W-1:0]    hold_cnt;

    // Only counted once the reference is aligned
    assign mismatch  = bits.armed & (bits.ref_bit ^ bits.iob_bit);
    assign hold_done = (hold_cnt == HOLD_W'(ERROR_HOLD - 1));

    // ====================
    // Mismatch counter
    // ====================

    // Frozen at ERROR_COUNT while the flag is held
    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            err_cnt <= '0;
            error   <= 1'b0;
        end else if (error) begin
            if (hold_done) begin
                err_cnt <= '0;
                error   <= 1'b0;
            end
        end else if (mismatch) begin
            err_cnt <= err_cnt + 1'b1;
            // Flag rises together with the final count
            if (err_cnt == ERR_CNT_W'(ERROR_COUNT - 1)) begin
                error <= 1'b1;
            end
        end
    end

    // ====================
    // Hold timer
    // ====================

    // Runs only while the flag is up, data ignored
    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            hold_cnt <= '0;
        end else if (error) begin
            if (hold_done) begin
                hold_cnt <= '0;
            end else begin
                hold_cnt <= hold_cnt + 1'b1;
            end
        end
    end

endmodule

//--- design/link_tester_top.sv
`timescale 1ns/1ps

module link_tester_top #(
    parameter int ERROR_HOLD = 2500000
) (
    input  logic CLK,
    input  logic CLKDIV,
    input  logic RST,
    input  logic I_DAT,
    output logic O_DAT,
    output logic O_ERROR
);

    import link_test_pkg::*;

    logic       clkdiv_r;
    logic       ce;
    logic       ser_ready;
    logic       ref_bit;
    logic       armed;
    prbs_word_t word;
    bit_pair_t  bits;

    // ====================
    // Word strobe
    // ====================

    // CLKDIV sampled on the fast clock
    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            clkdiv_r <= 1'b0;
        end else begin
            clkdiv_r <= CLKDIV;
        end
    end

    // One cycle wide, just after the CLKDIV fall
    assign ce = clkdiv_r & ~CLKDIV;

    // ====================
    // Pipeline
    // ====================

    prbs_gen u_prbs_gen (
        .CLK  (CLK),
        .RST  (RST),
        .ce   (ce),
        .word (word)
    );

    word_serializer u_word_serializer (
        .CLK       (CLK),
        .CLKDIV    (CLKDIV),
        .RST       (RST),
        .word      (word),
        .ser_ready (ser_ready),
        .dat       (O_DAT)
    );

    ref_serializer u_ref_serializer (
        .CLK       (CLK),
        .RST       (RST),
        .word      (word),
        .ser_ready (ser_ready),
        .ref_bit   (ref_bit),
        .armed     (armed)
    );

    // Expected bit, returned bit and enable for the checker
    assign bits.ref_bit = ref_bit;
    assign bits.iob_bit = I_DAT;
    assign bits.armed   = armed;

    bit_error_monitor #(
        .ERROR_HOLD (ERROR_HOLD)
    ) u_bit_error_monitor (
        .CLK   (CLK),
        .RST   (RST),
        .bits  (bits),
        .error (O_ERROR)
    );

endmodule

//--- tb/tb_link_tester.sv
`timescale 1ns/1ps

module tb_link_tester;

    import link_test_pkg::*;

    localparam int HOLD_CYCLES = 64;

    logic CLK;
    logic CLKDIV;
    logic RST;
    logic I_DAT;
    logic O_DAT;
    logic O_ERROR;

    // Driver controls, only touched on the falling edge
    logic       rst_req;
    logic       invert_loop;
    logic       flip_now;
    int         flips_left;
    int         flip_gap;
    logic [2:0] div_phase;
    integer     seed;
    int         err_total;
    int         tests_ok;
    int         tests_bad;

    link_tester_top #(
        .ERROR_HOLD (HOLD_CYCLES)
    ) dut (
        .CLK     (CLK),
        .CLKDIV  (CLKDIV),
        .RST     (RST),
        .I_DAT   (I_DAT),
        .O_DAT   (O_DAT),
        .O_ERROR (O_ERROR)
    );

    // ====================
    // Clocks and drive
    // ====================

    initial begin
        CLK = 1'b0;
        forever begin
            #4 CLK = ~CLK;
        end
    end

    // Every input moves 1 ns after the rising edge
    // RST goes first so a CLKDIV rise in the same step sees it settled
    always @(posedge CLK) begin
        #1;
        RST = rst_req;
        // Divide by 8, high for phases 0 to 3
        div_phase = div_phase + 3'd1;
        CLKDIV = (div_phase < 3'd4);
        flip_now = 1'b0;
        if (flips_left > 0) begin
            if (flip_gap == 0) begin
                flip_now = 1'b1;
                flips_left = flips_left - 1;
                flip_gap = 2 + ($random(seed) & 15);
            end else begin
                flip_gap = flip_gap - 1;
            end
        end
        // Loopback with optional inversion and single bit errors
        I_DAT = O_DAT ^ invert_loop ^ flip_now;
    end

    // ====================
    // Helpers
    // ====================

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Error: time %0t, %s = %0h, expected %0h", $time, name, actual, expected);
            err_total = err_total + 1;
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout at %0t: %s", $time, what);
        err_total = err_total + 1;
    endtask

    task automatic log_test_result(input string name, input int errs_before);
        if (err_total == errs_before) begin
            $display("%s: ok", name);
            tests_ok = tests_ok + 1;
        end else begin
            $display("%s: %0d errors", name, err_total - errs_before);
            tests_bad = tests_bad + 1;
        end
    endtask

    // Two cycles of RST, outputs must be quiet throughout
    task automatic apply_reset();
        invert_loop = 1'b0;
        flips_left  = 0;
        @(negedge CLK);
        rst_req = 1'b1;
        repeat (2) begin
            @(negedge CLK);
            check_value("O_DAT", O_DAT, 0);
            check_value("O_ERROR", O_ERROR, 0);
        end
        rst_req = 1'b0;
    endtask

    // x^8+x^6+x^5+x^4+1, shift left, feedback into bit 0
    function automatic logic [7:0] lfsr_next(input logic [7:0] s);
        return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
    endfunction

    // Bit 0 lands two cycles after the CLKDIV fall
    // (strobe, then load), so phase 6
    task automatic collect_word(output logic [7:0] w);
        int waited;
        waited = 0;
        w = 8'h00;
        @(negedge CLK);
        while (div_phase != 3'd6 && waited < 16) begin
            @(negedge CLK);
            waited = waited + 1;
        end
        if (div_phase != 3'd6) begin
            report_timeout("word boundary on CLKDIV never came");
        end
        w[0] = O_DAT;
        for (int b = 1; b < 8; b++) begin
            @(negedge CLK);
            w[b] = O_DAT;
        end
    endtask

    task automatic wait_for_error(input logic level, input int limit, input string what);
        int waited;
        waited = 0;
        @(negedge CLK);
        while (O_ERROR !== level && waited < limit) begin
            @(negedge CLK);
            waited = waited + 1;
        end
        if (O_ERROR !== level) begin
            report_timeout(what);
        end
    endtask

    task automatic expect_error_for(input logic level, input int cycles);
        repeat (cycles) begin
            @(negedge CLK);
            check_value("O_ERROR", O_ERROR, level);
        end
    endtask

    // ====================
    // Directed tests
    // ====================

    task automatic reset_outputs_stay_low();
        int errs;
        errs = err_total;
        apply_reset();
        // Two CLKDIV periods, serializer still in its reset sequence
        repeat (16) begin
            @(negedge CLK);
            check_value("O_DAT", O_DAT, 0);
            check_value("O_ERROR", O_ERROR, 0);
        end
        log_test_result("reset_state", errs);
    endtask

    task automatic prbs_words_follow_lfsr();
        int errs;
        int n;
        logic [7:0] prev;
        logic [7:0] cur;
        errs = err_total;
        apply_reset();
        prev = 8'h00;
        n = 0;
        // Zero words while the serializer is held
        while (prev == 8'h00 && n < 20) begin
            collect_word(prev);
            n = n + 1;
        end
        if (prev == 8'h00) begin
            report_timeout("O_DAT never carried a nonzero word");
        end else begin
            for (int i = 0; i < 20; i++) begin
                collect_word(cur);
                check_value("O_DAT word", cur, lfsr_next(prev));
                prev = cur;
            end
        end
        log_test_result("prbs_stream", errs);
    endtask

    task automatic clean_loop_has_no_error();
        int errs;
        errs = err_total;
        apply_reset();
        expect_error_for(1'b0, 2000);
        log_test_result("clean_loopback", errs);
    endtask

    task automatic sparse_flips_raise_error();
        int errs;
        int waited;
        errs = err_total;
        apply_reset();
        // Well past armed, which needs ser_ready plus two words
        expect_error_for(1'b0, 100);
        flip_gap   = 0;
        flips_left = ERROR_COUNT - 1;
        waited = 0;
        while (flips_left > 0 && waited < 1000) begin
            @(negedge CLK);
            check_value("O_ERROR", O_ERROR, 0);
            waited = waited + 1;
        end
        if (flips_left > 0) begin
            report_timeout("bit flips were not all applied");
        end
        expect_error_for(1'b0, 40);
        // One short of the threshold so far
        flips_left = 2;
        wait_for_error(1'b1, 64, "O_ERROR did not rise after the extra flips");
        log_test_result("sparse_errors", errs);
    endtask

    task automatic error_holds_then_clears();
        int errs;
        errs = err_total;
        apply_reset();
        invert_loop = 1'b1;
        wait_for_error(1'b1, 300, "O_ERROR did not rise with inverted loopback");
        // Flag must ride out the hold on clean data
        invert_loop = 1'b0;
        expect_error_for(1'b1, HOLD_CYCLES - 4);
        wait_for_error(1'b0, 20, "O_ERROR did not fall after the hold time");
        expect_error_for(1'b0, 500);
        log_test_result("hold_and_recovery", errs);
    endtask

    // ====================
    // Sequence
    // ====================

    initial begin
        RST         = 1'b1;
        CLKDIV      = 1'b0;
        I_DAT       = 1'b0;
        rst_req     = 1'b1;
        invert_loop = 1'b0;
        flip_now    = 1'b0;
        flips_left  = 0;
        flip_gap    = 0;
        div_phase   = 3'd7;
        seed        = 32'h0133b46c;
        err_total   = 0;
        tests_ok    = 0;
        tests_bad   = 0;

        reset_outputs_stay_low();
        prbs_words_follow_lfsr();
        clean_loop_has_no_error();
        sparse_flips_raise_error();
        error_holds_then_clears();

        $display("Tests ok: %0d, with errors: %0d, errors in all: %0d",
                 tests_ok, tests_bad, err_total);
        if (err_total == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- project.f
design/link_test_pkg.sv
design/prbs_gen.sv
design/word_serializer.sv
design/ref_serializer.sv
design/bit_error_monitor.sv
design/link_tester_top.sv
tb/tb_link_tester.sv

//--- run_sim.sh
#!/bin/sh
# Build the link tester testbench with Verilator, run it, judge from the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing -Wno-fatal --top-module tb_link_tester \
    -f project.f --Mdir "$OBJ" -o tb_link_tester
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$OBJ/tb_link_tester" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "test passed" "$LOG"; then
    echo "Simulation result: pass"
    exit 0
else
    echo "Simulation result: fail"
    exit 1
fi
